//--- logic/lc4_pkg.sv
package lc4_pkg;

  typedef logic [15:0] word_t;    // data, address and instruction word
  typedef logic [2:0]  reg_sel_t; // r0..r7
  typedef logic [2:0]  nzp_t;     // {n, z, p}

  // stall code carried next to every instruction down the pipe
  typedef enum logic [1:0] {
    NONE     = 2'd0, // real instruction
    FLUSH    = 2'd2, // squashed by a taken branch, or reset bubble
    LOAD_USE = 2'd3  // bubble behind a load
  } stall_t;

  // insn[15:12], only the kept classes
  typedef enum logic [3:0] {
    BR    = 4'h0,
    ARITH = 4'h1,
    LOGIC = 4'h5,
    LDR   = 4'h6,
    STR   = 4'h7,
    CONST = 4'h9
  } opcode_t;

  localparam word_t RESET_PC = 16'h8200; // first fetch address
  localparam int    NUM_REGS = 8;

  typedef struct packed {
    reg_sel_t rs;        // first source, base for ldr/str
    reg_sel_t rt;        // second source, store data for str
    reg_sel_t rd;
    logic     rs_re;
    logic     rt_re;
    logic     rf_we;
    logic     nzp_we;
    logic     is_load;
    logic     is_store;
    logic     is_branch; // br with a nonzero mask
  } ctrl_t;

  typedef struct packed {
    word_t pc;
    word_t insn;
    ctrl_t ctrl;
    word_t rs_data;
    word_t rt_data;
  } dx_t;

  typedef struct packed {
    word_t pc;
    word_t insn;
    ctrl_t ctrl;
    word_t result;
    nzp_t  nzp;
  } xm_t;

  typedef struct packed {
    word_t pc;
    word_t insn;
    ctrl_t ctrl;
    word_t result; // load data already merged in for loads
    nzp_t  nzp;
  } mw_t;

endpackage

//--- logic/lc4_wb_if.sv
`timescale 1ns/1ns

// writeback bus, one writer (the core's wb stage) and two readers
interface lc4_wb_if (
  input logic i_gwe,
  input logic i_reset
);
  logic              rf_we;  // register write this cycle
  lc4_pkg::reg_sel_t wsel;
  lc4_pkg::word_t    data;
  logic              nzp_we;
  lc4_pkg::nzp_t     nzp;    // flags as committed, load flags included

  modport producer (output rf_we, wsel, data, nzp_we, nzp);

  modport rf (input rf_we, wsel, data, nzp_we, nzp);

  // hazard unit also samples the clock for its checks
  modport watch (input i_gwe, i_reset, rf_we, wsel, data, nzp_we, nzp);
endinterface

//--- logic/lc4_stage_reg.sv
`timescale 1ns/1ns

module lc4_stage_reg #(
  parameter type      payload_t = logic [15:0],
  parameter payload_t BUBBLE    = '0            // payload with every enable low
) (
  input  logic            i_gwe,
  input  logic            i_reset,
  input  logic            i_hold,        // keep contents
  input  logic            i_bubble,      // replace incoming insn with a bubble
  input  lc4_pkg::stall_t i_bubble_code,
  input  payload_t        i_data,
  input  lc4_pkg::stall_t i_stall,
  output payload_t        o_data,
  output lc4_pkg::stall_t o_stall
);

  always_ff @(posedge i_gwe) begin
    if (i_reset) begin
      o_data  <= BUBBLE;
      o_stall <= lc4_pkg::FLUSH; // whole pipe starts empty
    end else if (i_bubble) begin
      o_data  <= BUBBLE;
      o_stall <= i_bubble_code;
    end else if (!i_hold) begin
      o_data  <= i_data;
      o_stall <= i_stall;        // bubbles from upstream keep their code
    end
  end

  // the stage driving us must pick one: hold the insn or drop it
  assert property (@(posedge i_gwe) disable iff (i_reset) !(i_hold && i_bubble))
    else $error("stage register asked to hold and bubble in the same cycle");

endmodule

//--- logic/lc4_decoder.sv
`timescale 1ns/1ns

module lc4_decoder (
  input  lc4_pkg::word_t i_insn,
  output lc4_pkg::ctrl_t o_ctrl
);

  logic [2:0] sub_op;   // function field of arith/logic
  logic       imm_form; // insn[5] selects the imm5 form

  assign sub_op   = i_insn[5:3];
  assign imm_form = i_insn[5];

  always_comb begin
    o_ctrl    = '0;            // unsupported encodings end up as a no-op
    o_ctrl.rd = i_insn[11:9];
    o_ctrl.rs = i_insn[8:6];
    o_ctrl.rt = i_insn[2:0];

    case (lc4_pkg::opcode_t'(i_insn[15:12]))
      lc4_pkg::BR: begin
        o_ctrl.is_branch = |i_insn[11:9]; // mask 000 is the lc4 nop
      end
      lc4_pkg::ARITH: begin
        // add, sub, add-imm; mul and div fall through as no-ops
        if (imm_form || sub_op == 3'b000 || sub_op == 3'b010) begin
          o_ctrl.rs_re  = 1'b1;
          o_ctrl.rt_re  = !imm_form;
          o_ctrl.rf_we  = 1'b1;
          o_ctrl.nzp_we = 1'b1;
        end
      end
      lc4_pkg::LOGIC: begin
        // and, or, xor register forms only
        if (!imm_form && (sub_op == 3'b000 || sub_op == 3'b010 || sub_op == 3'b011)) begin
          o_ctrl.rs_re  = 1'b1;
          o_ctrl.rt_re  = 1'b1;
          o_ctrl.rf_we  = 1'b1;
          o_ctrl.nzp_we = 1'b1;
        end
      end
      lc4_pkg::LDR: begin
        o_ctrl.rs_re   = 1'b1;   // base
        o_ctrl.rf_we   = 1'b1;
        o_ctrl.nzp_we  = 1'b1;   // flags fixed up in writeback
        o_ctrl.is_load = 1'b1;
      end
      lc4_pkg::STR: begin
        o_ctrl.rt       = i_insn[11:9]; // data register sits in the rd field
        o_ctrl.rs_re    = 1'b1;
        o_ctrl.rt_re    = 1'b1;
        o_ctrl.is_store = 1'b1;
      end
      lc4_pkg::CONST: begin
        o_ctrl.rf_we  = 1'b1;
        o_ctrl.nzp_we = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- logic/lc4_alu.sv
`timescale 1ns/1ns

module lc4_alu (
  input  lc4_pkg::word_t i_insn,
  input  lc4_pkg::word_t i_pc,
  input  lc4_pkg::word_t i_op_a,  // rs after bypass
  input  lc4_pkg::word_t i_op_b,  // rt after bypass
  output lc4_pkg::word_t o_result
);

  lc4_pkg::word_t imm5;
  lc4_pkg::word_t imm6;
  lc4_pkg::word_t imm9;

  assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
  assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
  assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

  // the decoder already blocks writes from unsupported sub-ops
  always_comb begin
    case (lc4_pkg::opcode_t'(i_insn[15:12]))
      lc4_pkg::BR:    o_result = i_pc + 16'd1 + imm9; // branch target
      lc4_pkg::ARITH: begin
        if (i_insn[5])
          o_result = i_op_a + imm5;
        else if (i_insn[4:3] == 2'b10)
          o_result = i_op_a - i_op_b;                 // sub
        else
          o_result = i_op_a + i_op_b;
      end
      lc4_pkg::LOGIC: begin
        case (i_insn[4:3])
          2'b10:   o_result = i_op_a | i_op_b;
          2'b11:   o_result = i_op_a ^ i_op_b;
          default: o_result = i_op_a & i_op_b;
        endcase
      end
      lc4_pkg::LDR,
      lc4_pkg::STR:   o_result = i_op_a + imm6;       // effective address
      lc4_pkg::CONST: o_result = imm9;
      default:        o_result = '0;
    endcase
  end

endmodule

//--- logic/lc4_regfile.sv
`timescale 1ns/1ns

module lc4_regfile (
  input  logic              i_gwe,
  input  logic              i_reset,
  input  lc4_pkg::reg_sel_t i_rs,
  input  lc4_pkg::reg_sel_t i_rt,
  output lc4_pkg::word_t    o_rs_data,
  output lc4_pkg::word_t    o_rt_data,
  output lc4_pkg::nzp_t     o_nzp,
  lc4_wb_if.rf              wb
);

  lc4_pkg::word_t regs [lc4_pkg::NUM_REGS];
  lc4_pkg::nzp_t  nzp_q; // committed condition flags

  always_ff @(posedge i_gwe) begin
    if (i_reset) begin
      for (int i = 0; i < lc4_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      nzp_q <= '0;
    end else begin
      if (wb.rf_we) regs[wb.wsel] <= wb.data;
      if (wb.nzp_we) nzp_q <= wb.nzp;
    end
  end

  // write-through so decode sees the value retiring this cycle
  assign o_rs_data = (wb.rf_we && wb.wsel == i_rs) ? wb.data : regs[i_rs];
  assign o_rt_data = (wb.rf_we && wb.wsel == i_rt) ? wb.data : regs[i_rt];
  assign o_nzp     = nzp_q; // wb forwarding of flags is in the hazard unit

endmodule

//--- logic/lc4_hazard_unit.sv
`timescale 1ns/1ns

module lc4_hazard_unit (
  input  lc4_pkg::ctrl_t i_d_ctrl,
  input  lc4_pkg::ctrl_t i_x_ctrl,
  input  lc4_pkg::word_t i_x_insn,
  input  lc4_pkg::word_t i_x_rs_data,
  input  lc4_pkg::word_t i_x_rt_data,
  input  lc4_pkg::ctrl_t i_m_ctrl,
  input  lc4_pkg::word_t i_m_result,
  input  lc4_pkg::nzp_t  i_m_nzp,
  input  lc4_pkg::nzp_t  i_rf_nzp,
  lc4_wb_if.watch        wb,
  output lc4_pkg::word_t o_op_a,
  output lc4_pkg::word_t o_op_b,
  output logic           o_stall_load_use,
  output logic           o_flush,
  output lc4_pkg::nzp_t  o_branch_nzp
);

  logic m_fwd;    // memory stage holds a usable result
  logic rs_dep;   // decode reads the register a load in execute will write
  logic rt_dep;
  logic load_use;

  assign m_fwd = i_m_ctrl.rf_we && !i_m_ctrl.is_load; // load data not back yet

  // youngest writer wins: memory, then writeback, then the value read in decode
  assign o_op_a = (m_fwd && i_m_ctrl.rd == i_x_ctrl.rs)     ? i_m_result :
                  (wb.rf_we && wb.wsel == i_x_ctrl.rs)       ? wb.data    : i_x_rs_data;
  assign o_op_b = (m_fwd && i_m_ctrl.rd == i_x_ctrl.rt)     ? i_m_result :
                  (wb.rf_we && wb.wsel == i_x_ctrl.rt)       ? wb.data    : i_x_rt_data;

  // a load in memory never feeds a branch here, the stall below keeps them apart
  assign o_branch_nzp = i_m_ctrl.nzp_we ? i_m_nzp :
                        wb.nzp_we       ? wb.nzp  : i_rf_nzp;

  assign rs_dep = i_d_ctrl.rs_re && i_d_ctrl.rs == i_x_ctrl.rd;
  assign rt_dep = i_d_ctrl.rt_re && i_d_ctrl.rt == i_x_ctrl.rd;

  // a branch right behind a load also waits, its flags come from the load data
  assign load_use = i_x_ctrl.is_load && (rs_dep || rt_dep || i_d_ctrl.is_branch);

  assign o_flush          = i_x_ctrl.is_branch && |(i_x_insn[11:9] & o_branch_nzp);
  assign o_stall_load_use = load_use && !o_flush; // flush squashes decode anyway

  // after a stall or a flush execute holds a bubble, so no second stall follows
  assert property (@(posedge wb.i_gwe) disable iff (wb.i_reset)
    (o_stall_load_use || o_flush) |=> !o_stall_load_use)
    else $error("load-use stall right after a stall or flush");

endmodule

//--- logic/lc4_core.sv
`timescale 1ns/1ns

module lc4_core (
  input  logic              i_gwe,
  input  logic              i_reset,
  output lc4_pkg::word_t    o_imem_addr,   // pc for the next cycle
  input  lc4_pkg::word_t    i_imem_insn,
  output lc4_pkg::word_t    o_dmem_addr,   // from execute
  output logic              o_dmem_we,
  output lc4_pkg::word_t    o_dmem_wdata,
  input  lc4_pkg::word_t    i_dmem_rdata,  // valid during memory
  output lc4_pkg::stall_t   o_wb_stall,
  output lc4_pkg::word_t    o_wb_pc,
  output lc4_pkg::word_t    o_wb_insn,
  output logic              o_wb_rf_we,
  output lc4_pkg::reg_sel_t o_wb_rf_wsel,
  output lc4_pkg::word_t    o_wb_rf_data,
  output logic              o_wb_nzp_we,
  output lc4_pkg::nzp_t     o_wb_nzp
);

  function automatic lc4_pkg::nzp_t nzp_of(input lc4_pkg::word_t v);
    return {v[15], v == 16'h0000, !v[15] && v != 16'h0000};
  endfunction

  lc4_pkg::word_t  pc;
  lc4_pkg::word_t  pc_next;
  lc4_pkg::word_t  fd_pc;         // fetch to decode
  lc4_pkg::word_t  fd_insn;
  lc4_pkg::stall_t fd_stall;
  lc4_pkg::ctrl_t  d_ctrl;
  lc4_pkg::word_t  d_rs_data;
  lc4_pkg::word_t  d_rt_data;
  lc4_pkg::nzp_t   rf_nzp;
  lc4_pkg::stall_t d_bubble_code;
  lc4_pkg::dx_t    dx_in;
  lc4_pkg::dx_t    x;
  lc4_pkg::xm_t    xm_in;
  lc4_pkg::xm_t    m;
  lc4_pkg::mw_t    mw_in;
  lc4_pkg::mw_t    w;
  lc4_pkg::stall_t x_stall;
  lc4_pkg::stall_t m_stall;
  lc4_pkg::stall_t w_stall;
  lc4_pkg::word_t  op_a;
  lc4_pkg::word_t  op_b;
  lc4_pkg::word_t  x_result;
  lc4_pkg::nzp_t   branch_nzp;
  logic            stall;         // load-use
  logic            flush;         // taken branch in execute

  lc4_wb_if wb_bus (.i_gwe(i_gwe), .i_reset(i_reset));

  always_comb begin
    if (i_reset)    pc_next = lc4_pkg::RESET_PC;
    else if (flush) pc_next = x_result;       // pc+1+imm9 from the alu
    else if (stall) pc_next = pc;             // refetch the same word
    else            pc_next = pc + 16'd1;
  end

  always_ff @(posedge i_gwe) pc <= pc_next;
  assign o_imem_addr = pc_next; // memory answers one edge later, lined up with pc

  always_ff @(posedge i_gwe) begin
    if (i_reset || flush) begin
      fd_insn  <= '0;                // decodes as br with an empty mask
      fd_stall <= lc4_pkg::FLUSH;
    end else if (!stall) begin
      fd_pc    <= pc;
      fd_insn  <= i_imem_insn;
      fd_stall <= lc4_pkg::NONE;
    end
  end

  lc4_decoder u_decoder (.i_insn(fd_insn), .o_ctrl(d_ctrl));

  lc4_regfile u_regfile (
    .i_gwe(i_gwe), .i_reset(i_reset), .i_rs(d_ctrl.rs), .i_rt(d_ctrl.rt),
    .o_rs_data(d_rs_data), .o_rt_data(d_rt_data), .o_nzp(rf_nzp), .wb(wb_bus.rf));

  assign dx_in = '{pc: fd_pc, insn: fd_insn, ctrl: d_ctrl,
                   rs_data: d_rs_data, rt_data: d_rt_data};
  assign d_bubble_code = flush ? lc4_pkg::FLUSH : lc4_pkg::LOAD_USE;

  lc4_stage_reg #(.payload_t(lc4_pkg::dx_t), .BUBBLE(lc4_pkg::dx_t'('0))) d_reg (
    .i_gwe(i_gwe), .i_reset(i_reset), .i_hold(1'b0), .i_bubble(flush || stall),
    .i_bubble_code(d_bubble_code), .i_data(dx_in), .i_stall(fd_stall),
    .o_data(x), .o_stall(x_stall));

  lc4_hazard_unit u_hazard (
    .i_d_ctrl(d_ctrl), .i_x_ctrl(x.ctrl), .i_x_insn(x.insn),
    .i_x_rs_data(x.rs_data), .i_x_rt_data(x.rt_data), .i_m_ctrl(m.ctrl),
    .i_m_result(m.result), .i_m_nzp(m.nzp), .i_rf_nzp(rf_nzp), .wb(wb_bus.watch),
    .o_op_a(op_a), .o_op_b(op_b), .o_stall_load_use(stall), .o_flush(flush),
    .o_branch_nzp(branch_nzp));

  lc4_alu u_alu (.i_insn(x.insn), .i_pc(x.pc), .i_op_a(op_a), .i_op_b(op_b),
                 .o_result(x_result));

  // insns that leave the flags alone carry the flags they saw
  assign xm_in = '{pc: x.pc, insn: x.insn, ctrl: x.ctrl, result: x_result,
                   nzp: x.ctrl.nzp_we ? nzp_of(x_result) : branch_nzp};

  assign o_dmem_addr  = x_result;
  assign o_dmem_we    = x.ctrl.is_store; // bubbles carry no store
  assign o_dmem_wdata = op_b;            // bypassed rt

  lc4_stage_reg #(.payload_t(lc4_pkg::xm_t), .BUBBLE(lc4_pkg::xm_t'('0))) m_reg (
    .i_gwe(i_gwe), .i_reset(i_reset), .i_hold(1'b0), .i_bubble(1'b0),
    .i_bubble_code(lc4_pkg::FLUSH), .i_data(xm_in), .i_stall(x_stall),
    .o_data(m), .o_stall(m_stall));

  // load word is registered here together with the rest of the payload
  assign mw_in = '{pc: m.pc, insn: m.insn, ctrl: m.ctrl, nzp: m.nzp,
                   result: m.ctrl.is_load ? i_dmem_rdata : m.result};

  lc4_stage_reg #(.payload_t(lc4_pkg::mw_t), .BUBBLE(lc4_pkg::mw_t'('0))) w_reg (
    .i_gwe(i_gwe), .i_reset(i_reset), .i_hold(1'b0), .i_bubble(1'b0),
    .i_bubble_code(lc4_pkg::FLUSH), .i_data(mw_in), .i_stall(m_stall),
    .o_data(w), .o_stall(w_stall));

  // writeback drives the bus, producer side
  assign wb_bus.rf_we  = w.ctrl.rf_we;
  assign wb_bus.wsel   = w.ctrl.rd;
  assign wb_bus.data   = w.result;
  assign wb_bus.nzp_we = w.ctrl.nzp_we;
  assign wb_bus.nzp    = w.ctrl.is_load ? nzp_of(w.result) : w.nzp; // load flags here

  assign o_wb_stall   = w_stall;
  assign o_wb_pc      = w.pc;
  assign o_wb_insn    = w.insn;
  assign o_wb_rf_we   = wb_bus.rf_we;
  assign o_wb_rf_wsel = wb_bus.wsel;
  assign o_wb_rf_data = wb_bus.data;
  assign o_wb_nzp_we  = wb_bus.nzp_we;
  assign o_wb_nzp     = wb_bus.nzp;

endmodule

//--- dv/lc4_core_checker.sv
`timescale 1ns/1ns

module lc4_core_checker (
  input  logic              i_gwe,
  input  logic              i_reset,
  input  lc4_pkg::stall_t   i_wb_stall,
  input  lc4_pkg::word_t    i_wb_pc,
  input  lc4_pkg::word_t    i_wb_insn,
  input  logic              i_wb_rf_we,
  input  lc4_pkg::reg_sel_t i_wb_rf_wsel,
  input  lc4_pkg::word_t    i_wb_rf_data,
  input  logic              i_wb_nzp_we,
  input  lc4_pkg::nzp_t     i_wb_nzp,
  input  logic              i_dmem_we,
  input  logic [127:0]      i_exp_rec,  // {tag, pc, insn, rf_we, wsel, data, nzp_we, nzp}
  input  lc4_pkg::word_t    i_next_tag, // tag of the following record or 0 past the end
  input  int                i_rec_count,
  output int                o_rec_idx,
  output int                o_errors,
  output logic              o_done
);

  int              test_errs;    // errors in the running test
  int              test_recs;
  int              tests_run;
  int              tests_failed;
  int              reset_errs;
  int              gap_cnt;      // bubble cycles since the last commit
  lc4_pkg::stall_t gap_code;
  logic            committed;    // first real insn seen

  initial begin
    o_rec_idx    = 0;
    o_errors     = 0;
    o_done       = 1'b0;
    test_errs    = 0;
    test_recs    = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset_errs   = 0;
    gap_cnt      = 0;
    gap_code     = lc4_pkg::NONE;
    committed    = 1'b0;
  end

  task automatic compare(input string field, input lc4_pkg::word_t exp, input lc4_pkg::word_t got);
    if (exp !== got) begin
      $display("mismatch at %0t: pc %h %s expected %h got %h", $time, i_wb_pc, field, exp, got);
      o_errors++;
      test_errs++;
    end
  endtask

  task automatic report_test(input int id, input int errs, input int recs);
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("test %0d: %0d records, %0d errors, %s", id, recs, errs,
             (errs != 0) ? "failed" : "ok");
  endtask

  task automatic check_record();
    lc4_pkg::word_t tag;
    tag = i_exp_rec[127:112];
    if (!committed) begin
      committed = 1'b1;
      if (i_wb_pc !== lc4_pkg::RESET_PC) begin   // pipe must start at the reset vector
        $display("mismatch at %0t: first committed pc %h, expected %h", $time, i_wb_pc,
                 lc4_pkg::RESET_PC);
        o_errors++;
        reset_errs++;
      end
      report_test(5, reset_errs, 1);
    end
    if (tag[15:12] != 4'h1) begin   // first record has no defined gap
      compare("bubble count", {12'h000, tag[7:4]}, 16'(gap_cnt));
      if (tag[7:4] != 4'h0) compare("bubble code", {12'h000, tag[11:8]}, {14'h0, gap_code});
    end
    compare("pc", i_exp_rec[111:96], i_wb_pc);
    compare("insn", i_exp_rec[95:80], i_wb_insn);
    compare("rf_we", i_exp_rec[79:64], {15'h0, i_wb_rf_we});
    if (i_exp_rec[64]) begin
      compare("wsel", i_exp_rec[63:48], {13'h0, i_wb_rf_wsel});
      compare("data", i_exp_rec[47:32], i_wb_rf_data);
    end
    compare("nzp_we", i_exp_rec[31:16], {15'h0, i_wb_nzp_we});
    if (i_exp_rec[16]) compare("nzp", i_exp_rec[15:0], {13'h0, i_wb_nzp});
    test_recs++;
    if (i_next_tag[3:0] != tag[3:0]) begin   // last record of this test
      report_test(tag[3:0], test_errs, test_recs);
      test_errs = 0;
      test_recs = 0;
    end
    o_rec_idx++;
  endtask

  // outputs settle well before the falling edge
  always @(negedge i_gwe) begin
    if (!i_reset && !o_done) begin
      if (!committed && i_wb_stall != lc4_pkg::NONE &&
          (i_wb_rf_we || i_wb_nzp_we || i_dmem_we)) begin
        $display("error at %0t: register, flag or memory write before the first commit", $time);
        o_errors++;
        reset_errs++;
      end
      if (i_wb_stall != lc4_pkg::NONE) begin
        gap_cnt++;
        gap_code = i_wb_stall;
      end else begin
        check_record();
        gap_cnt = 0;
      end
      if (o_rec_idx == i_rec_count) begin
        $display("checked %0d records in %0d tests, %0d tests failed, %0d errors",
                 o_rec_idx, tests_run, tests_failed, o_errors);
        o_done = 1'b1;
      end
    end
  end

endmodule

//--- dv/lc4_core_tb.sv
`timescale 1ns/1ns

module lc4_core_tb;

  logic              gwe;
  logic              reset;
  lc4_pkg::word_t    imem_addr;
  lc4_pkg::word_t    imem_insn;
  lc4_pkg::word_t    dmem_addr;
  logic              dmem_we;
  lc4_pkg::word_t    dmem_wdata;
  lc4_pkg::word_t    dmem_rdata;
  lc4_pkg::stall_t   wb_stall;
  lc4_pkg::word_t    wb_pc;
  lc4_pkg::word_t    wb_insn;
  logic              wb_rf_we;
  lc4_pkg::reg_sel_t wb_rf_wsel;
  lc4_pkg::word_t    wb_rf_data;
  logic              wb_nzp_we;
  lc4_pkg::nzp_t     wb_nzp;

  lc4_pkg::word_t image [0:1023]; // 000 program, 100 data, 1ff count, 200 records
  lc4_pkg::word_t imem  [0:255];  // words from RESET_PC up
  lc4_pkg::word_t dmem  [0:255];
  int             rec_count;
  int             rec_idx;
  int             errors;
  logic           done;
  logic           load_done;
  logic [127:0]   exp_rec;
  lc4_pkg::word_t next_tag;

  lc4_core u_dut (
    .i_gwe(gwe), .i_reset(reset), .o_imem_addr(imem_addr), .i_imem_insn(imem_insn),
    .o_dmem_addr(dmem_addr), .o_dmem_we(dmem_we), .o_dmem_wdata(dmem_wdata),
    .i_dmem_rdata(dmem_rdata), .o_wb_stall(wb_stall), .o_wb_pc(wb_pc), .o_wb_insn(wb_insn),
    .o_wb_rf_we(wb_rf_we), .o_wb_rf_wsel(wb_rf_wsel), .o_wb_rf_data(wb_rf_data),
    .o_wb_nzp_we(wb_nzp_we), .o_wb_nzp(wb_nzp));

  lc4_core_checker u_checker (
    .i_gwe(gwe), .i_reset(reset), .i_wb_stall(wb_stall), .i_wb_pc(wb_pc),
    .i_wb_insn(wb_insn), .i_wb_rf_we(wb_rf_we), .i_wb_rf_wsel(wb_rf_wsel),
    .i_wb_rf_data(wb_rf_data), .i_wb_nzp_we(wb_nzp_we), .i_wb_nzp(wb_nzp),
    .i_dmem_we(dmem_we), .i_exp_rec(exp_rec), .i_next_tag(next_tag),
    .i_rec_count(rec_count), .o_rec_idx(rec_idx), .o_errors(errors), .o_done(done));

  function automatic logic [127:0] record_at(input int idx);
    logic [127:0] r;
    r = '0;
    for (int k = 0; k < 8; k++) begin
      r = {r[111:0], image[512 + 8 * idx + k]};
    end
    return r;
  endfunction

  // outside the program window the core sees nops
  function automatic lc4_pkg::word_t fetch_word(input lc4_pkg::word_t addr);
    lc4_pkg::word_t offset;
    offset = addr - lc4_pkg::RESET_PC;
    return (addr >= lc4_pkg::RESET_PC && offset < 16'd256) ? imem[offset[7:0]] : 16'h0000;
  endfunction

  always #5 gwe = ~gwe;

  // expected record for the next commit, checker reads it at the falling edge
  always @(posedge gwe) begin
    exp_rec  <= record_at(rec_idx);
    next_tag <= (rec_idx + 1 < rec_count) ? image[512 + 8 * (rec_idx + 1)] : 16'h0000;
  end

  // one-cycle memories with stores landing at the same edge
  always @(posedge gwe) begin
    imem_insn  <= fetch_word(imem_addr);
    dmem_rdata <= dmem[dmem_addr[7:0]];
    if (dmem_we) dmem[dmem_addr[7:0]] <= dmem_wdata;
  end

  initial begin
    gwe        = 1'b0;
    reset      = 1'b1;
    imem_insn  = '0;
    dmem_rdata = '0;
    load_done  = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      image[i] = (i >= 256 && i < 512) ? {~i[7:0], i[7:0]} : 16'h0000; // data fill by address
    end
    $readmemh("dv/lc4_program_input.hex", image);
    for (int i = 0; i < 256; i++) begin
      imem[i] = image[i];
      dmem[i] = image[256 + i];
    end
    rec_count = image[511];
    load_done = 1'b1;
    if (rec_count < 1 || rec_count > 64) begin
      $display("data file holds no usable record count (%0d)", rec_count);
      $display("FAIL: see errors above");
      $finish;
    end else begin
      repeat (8) @(posedge gwe);
      reset <= 1'b0;
      wait (done);
      if (errors == 0) $display("PASS: all tests");
      else $display("FAIL: see errors above");
      $finish;
    end
  end

  // about four cycles per commit plus pipeline fill and reset
  initial begin
    wait (load_done);
    repeat (4 * rec_count + 40 + 8) @(posedge gwe);
    $display("timeout: only %0d of %0d records committed in time", rec_idx, rec_count);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- lc4_pipe.f
logic/lc4_pkg.sv
logic/lc4_wb_if.sv
logic/lc4_stage_reg.sv
logic/lc4_decoder.sv
logic/lc4_alu.sv
logic/lc4_regfile.sv
logic/lc4_hazard_unit.sv
logic/lc4_core.sv
dv/lc4_core_checker.sv
dv/lc4_core_tb.sv

//--- dv/lc4_program_input.hex
// @000 program words from pc 8200, @100 data memory, @1ff record count
// records: tag(flag,code,bubbles,test) pc insn rf_we wsel data nzp_we nzp
@000
9205 95FD 1642 1851 1ABC 5C81 5E52 569A
1891 9201 1241 1263 9407 1642 1853 1A84
9C10 9F9C 7F82 6382 1461 67BF 18C3 9A00
0402 9209 920A 1367 0805 95FF 0801 9603
9604
@10F
1234
@112
BEEF
@1FF
001E
// test 1 alu results and flags
1001 8200 9205 0001 0001 0005 0001 0001
0001 8201 95FD 0001 0002 FFFD 0001 0004
0001 8202 1642 0001 0003 0002 0001 0001
0001 8203 1851 0001 0004 0000 0001 0002
0001 8204 1ABC 0001 0005 FFF9 0001 0004
0001 8205 5C81 0001 0006 0005 0001 0001
0001 8206 5E52 0001 0007 FFFD 0001 0004
0001 8207 569A 0001 0003 0000 0001 0002
0001 8208 1891 0001 0004 FFF8 0001 0004
// test 2 bypass distances 1 to 3
0002 8209 9201 0001 0001 0001 0001 0001
0002 820A 1241 0001 0001 0002 0001 0001
0002 820B 1263 0001 0001 0005 0001 0001
0002 820C 9407 0001 0002 0007 0001 0001
0002 820D 1642 0001 0003 000C 0001 0001
0002 820E 1853 0001 0004 FFF9 0001 0004
0002 820F 1A84 0001 0005 0000 0001 0002
// test 3 store, load, load-use
0003 8210 9C10 0001 0006 0010 0001 0001
0003 8211 9F9C 0001 0007 FF9C 0001 0004
0003 8212 7F82 0000 0000 0000 0000 0000
0003 8213 6382 0001 0001 FF9C 0001 0004
0313 8214 1461 0001 0002 FF9D 0001 0004
0003 8215 67BF 0001 0003 1234 0001 0001
0313 8216 18C3 0001 0004 2468 0001 0001
// test 4 taken and not-taken branches
0004 8217 9A00 0001 0005 0000 0001 0002
0004 8218 0402 0000 0000 0000 0000 0000
0224 821B 1367 0001 0001 0007 0001 0001
0004 821C 0805 0000 0000 0000 0000 0000
0004 821D 95FF 0001 0002 FFFF 0001 0004
0004 821E 0801 0000 0000 0000 0000 0000
0224 8220 9604 0001 0003 0004 0001 0001
